/* all.f */
rtl/io_pkg.sv
rtl/io_periph_if.sv
rtl/io_bus_ctrl.sv
rtl/io_timer.sv
rtl/fan_pwm.sv
rtl/seg_display.sv
rtl/io_subsystem.sv
tb/tb_io_subsystem.sv

/* rtl/fan_pwm.sv */
`timescale 1ns/100ps

module fan_pwm #(
  parameter int unsigned PWM_BITS = 16
) (
  input  logic          clk_i,
  input  logic          rst_i,
  input  io_pkg::data_t speed_i,
  output logic          fan_o
);

  logic [PWM_BITS-1:0] cnt;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cnt   <= '0;
      fan_o <= 1'b0;
    end else begin
      cnt   <= cnt + 1'b1; // free running, wraps
      fan_o <= (cnt < speed_i[PWM_BITS-1:0]);
    end
  end

endmodule

/* rtl/io_bus_ctrl.sv */
`timescale 1ns/100ps

module io_bus_ctrl (
  input  logic          clk_i,
  input  logic          rst_i,
  input  logic          cyc_i,
  input  logic          stb_i,
  input  logic          we_i,
  input  io_pkg::adr_t  adr_i,
  input  io_pkg::data_t dat_i,
  output io_pkg::data_t dat_o,
  output logic          ack_o,
  input  logic [15:0]   sw_i,
  output logic [8:0]    led_o,
  output io_pkg::data_t segments_o,
  output io_pkg::data_t fan_speed_o,
  io_periph_if.master   timer_bus
);
  import io_pkg::*;

  ctrl_state_t state, state_next;
  region_t     region;
  data_t       result, result_next;
  data_t       seg_q, seg_next;
  data_t       fan_q, fan_next;
  logic [8:0]  led_q, led_next;

  assign region      = adr_i[15:12];
  assign ack_o       = (state == CTRL_DONE);
  assign dat_o       = result;
  assign led_o       = led_q;
  assign segments_o  = seg_q;
  assign fan_speed_o = fan_q;

  // timer sees the request only while busy
  assign timer_bus.cyc   = (state == CTRL_BUSY);
  assign timer_bus.stb   = (region == REGION_TIMER);
  assign timer_bus.we    = we_i;
  assign timer_bus.idx   = adr_i[3:2];
  assign timer_bus.wdata = dat_i;

  always_comb begin
    state_next  = state;
    result_next = result;
    seg_next    = seg_q;
    fan_next    = fan_q;
    led_next    = led_q;
    case (state)
      CTRL_IDLE: begin
        if (cyc_i && stb_i)
          state_next = CTRL_BUSY;
      end
      CTRL_BUSY: begin
        case (region)
          REGION_LOCAL: begin
            if (we_i) begin
              if (adr_i[2])
                fan_next = dat_i;
              else
                seg_next = dat_i;
            end else begin
              result_next = adr_i[2] ? fan_q : seg_q;
            end
            state_next = CTRL_DONE;
          end
          REGION_SWLED: begin
            if (we_i)
              led_next = dat_i[8:0];
            else
              result_next = {16'h0000, sw_i}; // zero-extended
            state_next = CTRL_DONE;
          end
          REGION_TIMER: begin
            if (timer_bus.ack) begin // wait for the timer
              if (!we_i)
                result_next = timer_bus.rdata;
              state_next = CTRL_DONE;
            end
          end
          default: begin // unmapped, finish at once
            if (!we_i)
              result_next = '0;
            state_next = CTRL_DONE;
          end
        endcase
      end
      CTRL_DONE: state_next = CTRL_IDLE;
      default:   state_next = CTRL_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state  <= CTRL_IDLE;
      result <= '0;
      seg_q  <= '0;
      fan_q  <= FAN_RESET_SPEED;
      led_q  <= '0;
    end else begin
      state  <= state_next;
      result <= result_next;
      seg_q  <= seg_next;
      fan_q  <= fan_next;
      led_q  <= led_next;
    end
  end

endmodule

/* rtl/io_periph_if.sv */
`timescale 1ns/100ps

interface io_periph_if;
  import io_pkg::*;

  logic     cyc;
  logic     stb;
  logic     we;
  reg_idx_t idx;
  data_t    wdata;
  data_t    rdata;
  logic     ack;

  modport master (
    output cyc, stb, we, idx, wdata,
    input  rdata, ack
  );

  modport slave (
    input  cyc, stb, we, idx, wdata,
    output rdata, ack
  );

endinterface

/* rtl/io_pkg.sv */
package io_pkg;

  typedef logic [31:0] data_t;
  typedef logic [16:0] adr_t;
  typedef logic [3:0]  region_t;  // adr bits 15:12
  typedef logic [1:0]  reg_idx_t; // adr bits 3:2
  typedef logic [6:0]  seg_t;     // active low, a..g

  typedef enum logic [1:0] {
    CTRL_IDLE = 2'd0,
    CTRL_BUSY = 2'd1,
    CTRL_DONE = 2'd2
  } ctrl_state_t;

  localparam region_t REGION_LOCAL = 4'h0; // seg word + fan speed
  localparam region_t REGION_SWLED = 4'h1;
  localparam region_t REGION_TIMER = 4'h8;

  localparam data_t FAN_RESET_SPEED = 32'h00008000;

endpackage

/* rtl/io_subsystem.sv */
`timescale 1ns/100ps

module io_subsystem #(
  parameter int unsigned PWM_BITS = 16
) (
  input  logic          clk_i,
  input  logic          rst_i,
  input  logic          cyc_i,
  input  logic          stb_i,
  input  logic          we_i,
  input  io_pkg::adr_t  adr_i,
  input  io_pkg::data_t dat_i,
  output io_pkg::data_t dat_o,
  output logic          ack_o,
  input  logic [15:0]   sw_i,
  output logic [8:0]    led_o,
  output logic [55:0]   hex_o,
  output logic          fan_o,
  output logic          irq_o
);
  import io_pkg::*;

  data_t segments;
  data_t fan_speed;

  io_periph_if timer_bus ();

  io_bus_ctrl ctrl_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cyc_i       (cyc_i),
    .stb_i       (stb_i),
    .we_i        (we_i),
    .adr_i       (adr_i),
    .dat_i       (dat_i),
    .dat_o       (dat_o),
    .ack_o       (ack_o),
    .sw_i        (sw_i),
    .led_o       (led_o),
    .segments_o  (segments),
    .fan_speed_o (fan_speed),
    .timer_bus   (timer_bus.master)
  );

  io_timer timer_i (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .bus   (timer_bus.slave),
    .irq_o (irq_o)
  );

  fan_pwm #(
    .PWM_BITS (PWM_BITS)
  ) fan_i (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .speed_i (fan_speed),
    .fan_o   (fan_o)
  );

  seg_display seg_i (
    .digits_i (segments),
    .hex_o    (hex_o)
  );

endmodule

/* rtl/io_timer.sv */
`timescale 1ns/100ps

module io_timer (
  input  logic       clk_i,
  input  logic       rst_i,
  io_periph_if.slave bus,
  output logic       irq_o
);
  import io_pkg::*;

  localparam reg_idx_t IDX_RELOAD = 2'd0;
  localparam reg_idx_t IDX_CTRL   = 2'd1;
  localparam reg_idx_t IDX_STATUS = 2'd2;
  localparam reg_idx_t IDX_COUNT  = 2'd3;

  data_t reload;
  data_t count;
  logic  en;
  logic  ie;
  logic  pending;
  logic  access;
  logic  wr;

  assign access = bus.cyc && bus.stb && !bus.ack; // one ack per request
  assign wr     = access && bus.we;
  assign irq_o  = pending && ie;

  // ack high for one cycle, one cycle after the request
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i)
      bus.ack <= 1'b0;
    else
      bus.ack <= access;
  end

  always_ff @(posedge clk_i) begin
    if (access && !bus.we) begin
      case (bus.idx)
        IDX_RELOAD: bus.rdata <= reload;
        IDX_CTRL:   bus.rdata <= {30'd0, ie, en};
        IDX_STATUS: bus.rdata <= {31'd0, pending};
        IDX_COUNT:  bus.rdata <= count;
      endcase
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      reload  <= '0;
      count   <= '0;
      en      <= 1'b0;
      ie      <= 1'b0;
      pending <= 1'b0;
    end else begin
      if (wr && bus.idx == IDX_CTRL) begin
        en <= bus.wdata[0];
        ie <= bus.wdata[1];
      end
      if (wr && bus.idx == IDX_STATUS && bus.wdata[0])
        pending <= 1'b0; // write 1 to clear
      if (wr && bus.idx == IDX_RELOAD) begin
        reload <= bus.wdata;
        count  <= bus.wdata;
      end else if (en) begin
        if (count == '0) begin
          count   <= reload;
          pending <= 1'b1; // a new expiry wins over the clear
        end else begin
          count <= count - 1'b1;
        end
      end
    end
  end

endmodule

/* rtl/seg_display.sv */
`timescale 1ns/100ps

module seg_display (
  input  io_pkg::data_t digits_i,
  output logic [55:0]   hex_o
);
  import io_pkg::*;

  // hex glyphs, segment a in bit 0, low = lit
  localparam seg_t GLYPHS [16] = '{
    7'h40, // 0
    7'h79, // 1
    7'h24, // 2
    7'h30, // 3
    7'h19, // 4
    7'h12, // 5
    7'h02, // 6
    7'h78, // 7
    7'h00, // 8
    7'h10, // 9
    7'h08, // A
    7'h03, // b
    7'h46, // C
    7'h21, // d
    7'h06, // E
    7'h0e  // F
  };

  for (genvar d = 0; d < 8; d++) begin : g_digit
    assign hex_o[d*7 +: 7] = GLYPHS[digits_i[d*4 +: 4]];
  end

endmodule

/* tb/tb_io_subsystem.sv */
`timescale 1ns/100ps

module tb_io_subsystem;
  import io_pkg::*;

  localparam int RESET_CYCLES = 8;
  localparam int N_RAND       = 60;
  localparam int N_TXN        = 1 + 4 + N_RAND + 13 + 2; // reset, fan, random, timer, final
  localparam int PWM_PERIOD   = 256;
  localparam int MAX_RELOAD   = 16;
  localparam int WATCHDOG_CYCLES =
    RESET_CYCLES + N_TXN * 10 + 4 * PWM_PERIOD + MAX_RELOAD + 4 + 8;

  logic        clk_i = 1'b0;
  logic        rst_i;
  logic        cyc_i, stb_i, we_i;
  adr_t        adr_i;
  data_t       dat_i, dat_o;
  logic        ack_o;
  logic [15:0] sw_i;
  logic [8:0]  led_o;
  logic [55:0] hex_o;
  logic        fan_o, irq_o;

  logic [31:0] lfsr = 32'h41c7225e;
  int          errors = 0;
  int          checks = 0;
  data_t       m_seg, m_fan; // reference model
  logic [8:0]  m_led;

  io_subsystem #(.PWM_BITS(8)) dut_i (
    .clk_i (clk_i), .rst_i (rst_i), .cyc_i (cyc_i), .stb_i (stb_i), .we_i (we_i),
    .adr_i (adr_i), .dat_i (dat_i), .dat_o (dat_o), .ack_o (ack_o), .sw_i (sw_i),
    .led_o (led_o), .hex_o (hex_o), .fan_o (fan_o), .irq_o (irq_o)
  );

  always #20 clk_i = ~clk_i;

  function automatic logic lfsr_bit();
    logic lsb;
    lsb  = lfsr[0];
    lfsr = lfsr >> 1;
    if (lsb)
      lfsr = lfsr ^ 32'h80200003;
    return lsb;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
      r = {r[30:0], lfsr_bit()};
    return r;
  endfunction

  // unused address bits are random so the decode must ignore them
  function automatic adr_t make_adr(region_t r, reg_idx_t idx);
    logic [31:0] b;
    b = rand_bits(11);
    return {b[10], r, b[9:2], idx, b[1:0]};
  endfunction

  function automatic seg_t glyph(logic [3:0] n);
    logic [6:0] lit; // gfedcba, high = lit
    case (n)
      4'h0: lit = 7'h3f;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5b;
      4'h3: lit = 7'h4f;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6d;
      4'h6: lit = 7'h7d;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7f;
      4'h9: lit = 7'h6f;
      4'ha: lit = 7'h77;
      4'hb: lit = 7'h7c;
      4'hc: lit = 7'h39;
      4'hd: lit = 7'h5e;
      4'he: lit = 7'h79;
      default: lit = 7'h71;
    endcase
    return ~lit;
  endfunction

  function automatic logic [55:0] expect_hex(data_t w);
    logic [55:0] h;
    for (int d = 0; d < 8; d++)
      h[d*7 +: 7] = glyph(w[d*4 +: 4]);
    return h;
  endfunction

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("ERROR at %0t: %s", $time, what);
    end
  endtask

  task automatic bus_cycle(input logic we, input adr_t adr, input data_t wdat,
                           output data_t rdat);
    int cycles;
    int exp_lat;
    cycles  = 0;
    exp_lat = (adr[15:12] == REGION_TIMER) ? 3 : 2;
    @(posedge clk_i);
    #2;
    cyc_i = 1'b1;
    stb_i = 1'b1;
    we_i  = we;
    adr_i = adr;
    dat_i = wdat;
    do begin
      @(posedge clk_i);
      #1;
      cycles++;
    end while (!ack_o && cycles < 8);
    expect_true(ack_o, "no ack_o within 8 cycles of the request");
    compare("ack_o latency", exp_lat, cycles);
    rdat = dat_o;
    @(posedge clk_i);
    #2;
    expect_true(!ack_o, "ack_o stayed high for more than one cycle");
    cyc_i = 1'b0;
    stb_i = 1'b0;
  endtask

  task automatic write_reg(input adr_t adr, input data_t d);
    data_t unused;
    bus_cycle(1'b1, adr, d, unused);
  endtask

  task automatic read_check(input adr_t adr, input data_t exp, input string name);
    data_t got;
    bus_cycle(1'b0, adr, rand_bits(32), got);
    compare(name, exp, got);
  endtask

  // one full PWM period sees every counter value once
  task automatic check_fan(input logic [7:0] exp);
    int highs;
    highs = 0;
    repeat (PWM_PERIOD) begin
      @(posedge clk_i);
      #1;
      if (fan_o)
        highs++;
    end
    compare("fan_o high cycles", exp, highs);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
    $display("tests failed");
    $finish;
  end

  initial begin
    data_t       d;
    logic [3:0]  r;
    logic [2:0]  op;
    int          waited;
    rst_i = 1'b1;
    cyc_i = 1'b0;
    stb_i = 1'b0;
    we_i  = 1'b0;
    adr_i = '0;
    dat_i = '0;
    sw_i  = '0;
    m_seg = '0;
    m_fan = FAN_RESET_SPEED;
    m_led = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #2;
    rst_i = 1'b0;

    compare("ack_o", 0, ack_o);
    compare("irq_o", 0, irq_o);
    compare("led_o", 0, led_o);
    compare("hex_o", expect_hex(32'h0), hex_o);
    read_check(make_adr(REGION_LOCAL, 2'd1), FAN_RESET_SPEED, "dat_o fan speed");

    repeat (4) begin
      d = rand_bits(32);
      write_reg(make_adr(REGION_LOCAL, 2'd1), d);
      m_fan = d;
      check_fan(d[7:0]);
    end

    for (int n = 0; n < N_RAND; n++) begin
      op = 3'(rand_bits(3));
      case (op)
        3'd0: begin
          d = rand_bits(32);
          write_reg(make_adr(REGION_LOCAL, 2'd0), d);
          m_seg = d;
          compare("hex_o", expect_hex(m_seg), hex_o);
        end
        3'd1: read_check(make_adr(REGION_LOCAL, 2'd0), m_seg, "dat_o segment word");
        3'd2: begin
          d = rand_bits(32);
          write_reg(make_adr(REGION_LOCAL, 2'd1), d);
          m_fan = d;
        end
        3'd3: read_check(make_adr(REGION_LOCAL, 2'd1), m_fan, "dat_o fan speed");
        3'd4: begin
          d = rand_bits(32);
          write_reg(make_adr(REGION_SWLED, 2'(rand_bits(2))), d);
          m_led = d[8:0];
          compare("led_o", m_led, led_o);
        end
        3'd5: begin
          @(posedge clk_i);
          #2;
          sw_i = 16'(rand_bits(16));
          read_check(make_adr(REGION_SWLED, 2'(rand_bits(2))), {16'h0, sw_i},
                     "dat_o switches");
        end
        default: begin
          r = 4'(rand_bits(4));
          if (r == REGION_LOCAL || r == REGION_SWLED || r == REGION_TIMER)
            r = r | 4'h2; // move off a mapped region
          read_check(make_adr(r, 2'(rand_bits(2))), 32'h0, "dat_o unmapped");
        end
      endcase
    end

    write_reg(make_adr(REGION_TIMER, 2'd1), 32'h0);
    d = rand_bits(32);
    write_reg(make_adr(REGION_TIMER, 2'd0), d);
    read_check(make_adr(REGION_TIMER, 2'd0), d, "timer reload");
    write_reg(make_adr(REGION_TIMER, 2'd1), 32'h2);
    read_check(make_adr(REGION_TIMER, 2'd1), 32'h2, "timer control");
    d = rand_bits(4) + 1;
    write_reg(make_adr(REGION_TIMER, 2'd0), d);
    write_reg(make_adr(REGION_TIMER, 2'd1), 32'h3); // enable + irq enable
    waited = 0;
    while (!irq_o && waited < d + 4) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    expect_true(irq_o, "irq_o did not rise within reload plus 4 cycles");
    read_check(make_adr(REGION_TIMER, 2'd2), 32'h1, "timer status");
    write_reg(make_adr(REGION_TIMER, 2'd1), 32'h2);
    write_reg(make_adr(REGION_TIMER, 2'd2), 32'h1);
    expect_true(!irq_o, "irq_o still high after clearing status");
    d = rand_bits(32);
    write_reg(make_adr(REGION_TIMER, 2'd0), d); // loads the count as well
    read_check(make_adr(REGION_TIMER, 2'd3), d, "timer count while disabled");
    repeat (5) @(posedge clk_i);
    read_check(make_adr(REGION_TIMER, 2'd3), d, "timer count while disabled");

    read_check(make_adr(REGION_LOCAL, 2'd0), m_seg, "dat_o segment word");
    read_check(make_adr(REGION_LOCAL, 2'd1), m_fan, "dat_o fan speed");
    compare("led_o", m_led, led_o);
    compare("hex_o", expect_hex(m_seg), hex_o);

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule
